/* Bender.yml */
package:
  name: qspinor

sources:
  - files:
      - logic/qspinor_pkg.sv
      - logic/qspinor_req_decode.sv
      - logic/qspinor_cfg_regs.sv
      - logic/qspinor_read_seq.sv
      - logic/qspinor_ctrl.sv
  - target: test
    files:
      - tb/flash_model.sv
      - tb/tb_qspinor.sv

/* logic/qspinor_cfg_regs.sv */
`timescale 1ns/10ps
`default_nettype none

module qspinor_cfg_regs (
    input  wire                           clk,
    input  wire                           rstn,
    input  wire                           reg_wr,
    input  wire                           reg_rd,
    input  wire  [qspinor_pkg::CFG_W-1:0] req_wdata,
    output qspinor_pkg::cfg_word_u        cfg,
    output logic                          reg_resp,
    output logic [qspinor_pkg::BUS_W-1:0] reg_rdata
);
    import qspinor_pkg::*;

    cfg_word_u wr_word;

    // incoming word with the reserved bits cleared
    always_comb begin
        wr_word.raw         = req_wdata;
        wr_word.fields.rsvd = '0;
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            // default read command, single mode, no dummy clocks
            cfg.raw <= {READ_CMD_RST, {(CFG_W-CMD_W){1'b0}}};
        end else if (reg_wr) begin
            cfg <= wr_word;
        end
    end

    // answer one cycle after the strobe
    always_ff @(posedge clk) begin
        if (!rstn) begin
            reg_resp <= 1'b0;
        end else begin
            reg_resp <= reg_wr | reg_rd;
        end
    end

    // zero-extended word on a read, zero otherwise
    always_ff @(posedge clk) begin
        reg_rdata <= reg_rd ? BUS_W'(cfg.raw) : '0;
    end

endmodule

`default_nettype wire

/* logic/qspinor_ctrl.sv */
`timescale 1ns/10ps
`default_nettype none

module qspinor_ctrl #(
    parameter int ADDR_W = 16
) (
    input  wire                           clk,
    input  wire                           rstn,
    input  wire                           req,
    input  wire                           wr_b,
    input  wire  [qspinor_pkg::ACC_W-1:0] acc,
    input  wire                           ctrl_sel,   // high for the register
    input  wire  [ADDR_W-1:0]             addr,
    input  wire  [qspinor_pkg::BUS_W-1:0] wdata,
    output logic                          resp,
    output logic [qspinor_pkg::BUS_W-1:0] rdata,
    output logic                          fault,
    output logic                          qspi_sck,
    output logic                          qspi_csb,
    inout  wire  [3:0]                    qspi_data
);
    import qspinor_pkg::*;

    logic             reg_wr;
    logic             reg_rd;
    logic             rd_req;
    logic [ADDR_W-1:0] req_addr;
    logic [ACC_W-1:0] req_acc;
    logic [CFG_W-1:0] req_wdata;
    cfg_word_u        cfg;
    logic             reg_resp;
    logic [BUS_W-1:0] reg_rdata;
    logic             rd_resp;
    logic [BUS_W-1:0] rd_data;
    logic [3:0]       pad_oe;
    logic [3:0]       pad_do;
    logic [3:0]       pad_di;

    qspinor_req_decode #(
        .ADDR_W(ADDR_W)
    ) u_decode (
        .clk      (clk),
        .rstn     (rstn),
        .req      (req),
        .wr_b     (wr_b),
        .ctrl_sel (ctrl_sel),
        .acc      (acc),
        .addr     (addr),
        .wdata    (wdata[CFG_W-1:0]),
        .fault    (fault),
        .reg_wr   (reg_wr),
        .reg_rd   (reg_rd),
        .rd_req   (rd_req),
        .req_addr (req_addr),
        .req_acc  (req_acc),
        .req_wdata(req_wdata)
    );

    qspinor_cfg_regs u_regs (
        .clk      (clk),
        .rstn     (rstn),
        .reg_wr   (reg_wr),
        .reg_rd   (reg_rd),
        .req_wdata(req_wdata),
        .cfg      (cfg),
        .reg_resp (reg_resp),
        .reg_rdata(reg_rdata)
    );

    qspinor_read_seq #(
        .ADDR_W(ADDR_W)
    ) u_seq (
        .clk     (clk),
        .rstn    (rstn),
        .rd_req  (rd_req),
        .req_addr(req_addr),
        .req_acc (req_acc),
        .cfg     (cfg),
        .pad_di  (pad_di),
        .rd_resp (rd_resp),
        .rd_data (rd_data),
        .csb     (qspi_csb),
        .sck     (qspi_sck),
        .pad_oe  (pad_oe),
        .pad_do  (pad_do)
    );

    // at most one of the two answers per cycle
    assign resp  = reg_resp | rd_resp;
    assign rdata = rd_resp ? rd_data : reg_rdata;

    for (genvar i = 0; i < 4; i++) begin : g_pad
        assign qspi_data[i] = pad_oe[i] ? pad_do[i] : 1'bz;
    end

    assign pad_di = qspi_data;

endmodule

`default_nettype wire

/* logic/qspinor_pkg.sv */
`default_nettype none

package qspinor_pkg;

    // bus side
    localparam int BUS_W = 32;
    localparam int ACC_W = 2;

    // access size codes, code 3 behaves as 4 bytes
    localparam logic [ACC_W-1:0] ACC_1B = 2'd0;
    localparam logic [ACC_W-1:0] ACC_2B = 2'd1;
    localparam logic [ACC_W-1:0] ACC_4B = 2'd2;

    // flash side
    localparam int CFG_W    = 16;
    localparam int FLASH_AW = 24;   // 3-byte addressing
    localparam int CMD_W    = 8;
    localparam int DUMMY_W  = 4;

    localparam int RSVD_W = CFG_W - CMD_W - DUMMY_W - 1;

    // plain 1-1-1 read on most serial NOR parts
    localparam logic [CMD_W-1:0] READ_CMD_RST = 8'h03;

    // control register 0
    // raw is the bus view, fields the decoded one
    typedef union packed {
        logic [CFG_W-1:0] raw;
        struct packed {
            logic [CMD_W-1:0]   read_cmd;      // 15:8
            logic [DUMMY_W-1:0] dummy_cycles;  // 7:4, zero for none
            logic [RSVD_W-1:0]  rsvd;          // reads as zero
            logic               quad_en;       // 4-4-4 when set
        } fields;
    } cfg_word_u;

endpackage

`default_nettype wire

/* logic/qspinor_read_seq.sv */
`timescale 1ns/10ps
`default_nettype none

module qspinor_read_seq #(
    parameter int ADDR_W = 16
) (
    input  wire                           clk,
    input  wire                           rstn,
    input  wire                           rd_req,
    input  wire  [ADDR_W-1:0]             req_addr,
    input  wire  [qspinor_pkg::ACC_W-1:0] req_acc,
    input  wire  qspinor_pkg::cfg_word_u  cfg,
    input  wire  [3:0]                    pad_di,
    output logic                          rd_resp,
    output logic [qspinor_pkg::BUS_W-1:0] rd_data,
    output logic                          csb,
    output logic                          sck,
    output logic [3:0]                    pad_oe,
    output logic [3:0]                    pad_do
);
    import qspinor_pkg::*;

    localparam int TX_W = CMD_W + FLASH_AW;

    localparam logic [1:0] ST_IDLE  = 2'd0;
    localparam logic [1:0] ST_CMD   = 2'd1;  // command and address out
    localparam logic [1:0] ST_DUMMY = 2'd2;
    localparam logic [1:0] ST_DATA  = 2'd3;  // data in

    logic [1:0]          state;
    cfg_word_u           cfg_q;       // settings of the running transaction
    logic [ACC_W-1:0]    acc_q;
    logic [TX_W-1:0]     tx_shift;
    logic [FLASH_AW-1:0] flash_addr;
    logic [5:0]          bit_cnt;
    logic [5:0]          bit_step;
    logic [5:0]          cmd_last;
    logic [5:0]          dummy_last;
    logic [5:0]          data_last;
    logic [4:0]          rx_pos;

    assign flash_addr = FLASH_AW'(req_addr);

    assign bit_step   = cfg_q.fields.quad_en ? 6'd4 : 6'd1;
    assign cmd_last   = 6'(TX_W) - bit_step;
    assign dummy_last = 6'(cfg_q.fields.dummy_cycles) - 6'd1;  // dummy clocks count by one

    always_comb begin
        case (acc_q)
            ACC_1B:  data_last = 6'd8 - bit_step;
            ACC_2B:  data_last = 6'd16 - bit_step;
            default: data_last = 6'd32 - bit_step;
        endcase
    end

    // byte n of the stream lands at [8n+7:8n], msb first inside the byte
    assign rx_pos = {bit_cnt[4:3], ~bit_cnt[2:0]};

    // line 0 only in single mode
    assign pad_do = cfg_q.fields.quad_en ? tx_shift[TX_W-1 -: 4] : {3'b000, tx_shift[TX_W-1]};

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state   <= ST_IDLE;
            csb     <= 1'b1;
            sck     <= 1'b0;
            pad_oe  <= 4'h0;
            rd_resp <= 1'b0;
            bit_cnt <= '0;
        end else begin
            rd_resp <= 1'b0;
            case (state)
                ST_IDLE: begin
                    sck <= 1'b0;
                    if (rd_req) begin
                        state   <= ST_CMD;
                        csb     <= 1'b0;
                        bit_cnt <= '0;
                        pad_oe  <= cfg.fields.quad_en ? 4'hf : 4'h1;
                    end
                end
                ST_CMD: begin
                    sck <= ~sck;
                    if (sck) begin                       // falling edge next
                        if (bit_cnt != cmd_last) begin
                            bit_cnt <= bit_cnt + bit_step;
                        end else begin
                            pad_oe  <= 4'h0;             // release pads for the flash
                            bit_cnt <= '0;
                            if (cfg_q.fields.dummy_cycles != '0) begin
                                state <= ST_DUMMY;
                            end else begin
                                state <= ST_DATA;
                            end
                        end
                    end
                end
                ST_DUMMY: begin
                    sck <= ~sck;
                    if (sck) begin
                        if (bit_cnt != dummy_last) begin
                            bit_cnt <= bit_cnt + 6'd1;
                        end else begin
                            bit_cnt <= '0;
                            state   <= ST_DATA;
                        end
                    end
                end
                default: begin
                    sck <= ~sck;
                    if (sck) begin
                        if (bit_cnt != data_last) begin
                            bit_cnt <= bit_cnt + bit_step;
                        end else begin
                            state   <= ST_IDLE;
                            csb     <= 1'b1;
                            rd_resp <= 1'b1;
                        end
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == ST_IDLE && rd_req) begin
            cfg_q    <= cfg;
            acc_q    <= req_acc;
            tx_shift <= {cfg.fields.read_cmd, flash_addr};
            rd_data  <= '0;                              // unread bytes stay zero
        end else begin
            if (state == ST_CMD && sck) begin
                tx_shift <= tx_shift << bit_step;
            end
            // sample just before the rising edge
            if (state == ST_DATA && !sck) begin
                if (cfg_q.fields.quad_en) begin
                    rd_data[{rx_pos[4:2], 2'b00} +: 4] <= pad_di;
                end else begin
                    rd_data[rx_pos] <= pad_di[1];        // flash drives line 1
                end
            end
        end
    end

endmodule

`default_nettype wire

/* logic/qspinor_req_decode.sv */
`timescale 1ns/10ps
`default_nettype none

module qspinor_req_decode #(
    parameter int ADDR_W = 16
) (
    input  wire                           clk,
    input  wire                           rstn,
    input  wire                           req,
    input  wire                           wr_b,
    input  wire                           ctrl_sel,
    input  wire  [qspinor_pkg::ACC_W-1:0] acc,
    input  wire  [ADDR_W-1:0]             addr,
    input  wire  [qspinor_pkg::CFG_W-1:0] wdata,
    output logic                          fault,
    output logic                          reg_wr,
    output logic                          reg_rd,
    output logic                          rd_req,
    output logic [ADDR_W-1:0]             req_addr,
    output logic [qspinor_pkg::ACC_W-1:0] req_acc,
    output logic [qspinor_pkg::CFG_W-1:0] req_wdata
);
    import qspinor_pkg::*;

    logic bad_write;
    logic bad_reg;
    logic accept;

    // flash window is read only
    assign bad_write = ~ctrl_sel & wr_b;

    // only register 0 exists, and only as a halfword
    assign bad_reg = ctrl_sel & ((addr[2:0] != 3'd0) | (acc != ACC_2B));

    assign fault  = req & (bad_write | bad_reg);
    assign accept = req & ~(bad_write | bad_reg);

    // one strobe per accepted request, a cycle later
    always_ff @(posedge clk) begin
        if (!rstn) begin
            reg_wr <= 1'b0;
            reg_rd <= 1'b0;
            rd_req <= 1'b0;
        end else begin
            reg_wr <= accept & ctrl_sel & wr_b;
            reg_rd <= accept & ctrl_sel & ~wr_b;
            rd_req <= accept & ~ctrl_sel;
        end
    end

    // request fields held until the next accepted request
    always_ff @(posedge clk) begin
        if (accept) begin
            req_addr  <= addr;
            req_acc   <= acc;
            req_wdata <= wdata;
        end
    end

endmodule

`default_nettype wire

/* sim.f */
logic/qspinor_pkg.sv
logic/qspinor_req_decode.sv
logic/qspinor_cfg_regs.sv
logic/qspinor_read_seq.sv
logic/qspinor_ctrl.sv
tb/flash_model.sv
tb/tb_qspinor.sv

/* tb/flash_model.sv */
`timescale 1ns/10ps
`default_nettype none

module flash_model (
    input  wire       sck,
    input  wire       csb,
    inout  wire [3:0] dq,
    input  wire       quad_en,        // 4-4-4 when set
    input  wire [3:0] dummy_cycles,
    input  wire [7:0] exp_cmd,
    output int        cmd_errors
);
    logic [3:0] dq_oe;
    logic [3:0] dq_out;

    for (genvar i = 0; i < 4; i++) begin : g_dq
        assign dq[i] = dq_oe[i] ? dq_out[i] : 1'bz;
    end

    // array contents, a fixed function of the byte address
    function automatic logic [7:0] byte_at(logic [23:0] a);
        return (a[7:0] * 8'd29) ^ a[15:8] ^ {a[19:16], a[23:20]} ^ 8'ha5;
    endfunction

    task automatic serve_read();
        logic        quad;
        logic [3:0]  dummy;
        logic [31:0] rx;
        logic [23:0] addr;
        logic [7:0]  cur;
        int          k;
        quad  = quad_en;     // settings held for the whole transaction
        dummy = dummy_cycles;
        rx    = '0;
        for (int i = 0; i < 32; i += (quad ? 4 : 1)) begin
            @(posedge sck);
            rx = quad ? {rx[27:0], dq} : {rx[30:0], dq[0]};
        end
        if (rx[31:24] !== exp_cmd) begin
            $display("flash model received command 0x%02h but 0x%02h was configured",
                     rx[31:24], exp_cmd);
            cmd_errors++;
        end
        addr = rx[23:0];
        repeat (dummy) @(posedge sck);
        // data changes on falling sck, a little after the edge
        k = 0;
        @(negedge sck);
        #1;
        while (!csb) begin
            cur = byte_at(addr + 24'(quad ? k / 2 : k / 8));
            if (quad) begin
                dq_out = (k % 2 == 0) ? cur[7:4] : cur[3:0];
                dq_oe  = 4'hf;
            end else begin
                dq_out = {2'b00, cur[7 - k % 8], 1'b0};   // single mode out on line 1
                dq_oe  = 4'h2;
            end
            k++;
            @(negedge sck or posedge csb);
            #1;
        end
        dq_oe = 4'h0;
    endtask

    initial begin
        dq_oe      = 4'h0;
        dq_out     = 4'h0;
        cmd_errors = 0;
        forever begin
            @(negedge csb);
            serve_read();
        end
    end

endmodule

`default_nettype wire

/* tb/tb_qspinor.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_qspinor;
    import qspinor_pkg::*;

    localparam int ADDR_W       = 16;
    localparam int REG_TIMEOUT  = 10;
    localparam int RD_TIMEOUT   = 400;   // slowest read is about 165 cycles
    localparam int NO_RESP_WAIT = RD_TIMEOUT;   // covers the slowest read

    logic              clk;
    logic              rstn;
    logic              req;
    logic              wr_b;
    logic              ctrl_sel;
    logic [ACC_W-1:0]  acc;
    logic [ADDR_W-1:0] addr;
    logic [BUS_W-1:0]  wdata;
    wire               resp;
    wire  [BUS_W-1:0]  rdata;
    wire               fault;
    wire               qspi_sck;
    wire               qspi_csb;
    wire  [3:0]        qspi_data;
    int                flash_errors;

    logic [31:0]       lfsr;
    logic [CFG_W-1:0]  cfg_model;    // expected control register
    logic              seen;
    logic [BUS_W-1:0]  got;
    logic              got_fault;
    int                errors;
    int                checks;
    int                csb_errors;
    int                csb_checks;
    int                err_mark;
    int                chk_mark;

    qspinor_ctrl #(
        .ADDR_W(ADDR_W)
    ) dut (
        .clk      (clk),
        .rstn     (rstn),
        .req      (req),
        .wr_b     (wr_b),
        .acc      (acc),
        .ctrl_sel (ctrl_sel),
        .addr     (addr),
        .wdata    (wdata),
        .resp     (resp),
        .rdata    (rdata),
        .fault    (fault),
        .qspi_sck (qspi_sck),
        .qspi_csb (qspi_csb),
        .qspi_data(qspi_data)
    );

    flash_model u_flash (
        .sck         (qspi_sck),
        .csb         (qspi_csb),
        .dq          (qspi_data),
        .quad_en     (cfg_model[0]),
        .dummy_cycles(cfg_model[7:4]),
        .exp_cmd     (cfg_model[15:8]),
        .cmd_errors  (flash_errors)
    );

    always #2 clk = ~clk;

    // fibonacci lfsr on x^32 + x^22 + x^2 + x + 1 stepped once per bit taken
    function automatic logic [31:0] rand_bits(int n);
        logic [31:0] v;
        logic        fb;
        v = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            v    = {v[30:0], fb};
        end
        return v;
    endfunction

    function automatic logic [7:0] byte_at(logic [23:0] a);
        return (a[7:0] * 8'd29) ^ a[15:8] ^ {a[19:16], a[23:20]} ^ 8'ha5;
    endfunction

    // first byte lands in [7:0] and unread bytes stay zero
    function automatic logic [BUS_W-1:0] expected_read(logic [ADDR_W-1:0] a,
                                                       logic [ACC_W-1:0] sz);
        logic [BUS_W-1:0] v;
        int               nbytes;
        v      = '0;
        nbytes = (sz == ACC_1B) ? 1 : (sz == ACC_2B) ? 2 : 4;
        for (int n = 0; n < nbytes; n++) begin
            v[8*n +: 8] = byte_at(24'(a) + 24'(n));
        end
        return v;
    endfunction

    task automatic report_mismatch(string name, logic [31:0] got_v, logic [31:0] exp_v);
        $display("[FAIL] %s got 0x%08h expected 0x%08h", name, got_v, exp_v);
        errors++;
    endtask

    task automatic report_error(string msg);
        $display("%s", msg);
        errors++;
    endtask

    task automatic send_request(logic wr, logic sel, logic [ACC_W-1:0] sz,
                                logic [ADDR_W-1:0] a, logic [BUS_W-1:0] d);
        @(posedge clk);
        req      <= 1'b1;
        wr_b     <= wr;
        ctrl_sel <= sel;
        acc      <= sz;
        addr     <= a;
        wdata    <= d;
        @(negedge clk);
        got_fault = fault;     // combinational in the request cycle
        csb_checks++;
        if (qspi_csb !== 1'b1) begin
            $display("qspi_csb was low between transactions");
            csb_errors++;
        end
        @(posedge clk);
        req <= 1'b0;
    endtask

    task automatic wait_resp(int limit);
        seen = 1'b0;
        got  = '0;
        for (int n = 0; n < limit && !seen; n++) begin
            @(negedge clk);
            if (resp === 1'b1) begin
                seen = 1'b1;
                got  = rdata;
                csb_checks++;
                if (qspi_csb !== 1'b1) begin
                    $display("qspi_csb was still low when resp arrived");
                    csb_errors++;
                end
            end
        end
    endtask

    task automatic expect_fault(logic exp);
        checks++;
        if (got_fault !== exp) begin
            report_mismatch("fault", 32'(got_fault), 32'(exp));
        end
    endtask

    task automatic write_cfg(logic [CFG_W-1:0] w);
        logic [BUS_W-1:0] d;
        d = {16'(rand_bits(16)), w};   // upper bus bits are ignored
        send_request(1'b1, 1'b1, ACC_2B, '0, d);
        expect_fault(1'b0);
        wait_resp(REG_TIMEOUT);
        checks++;
        if (!seen) begin
            report_error($sformatf("no resp within %0d cycles to a register write", REG_TIMEOUT));
        end
        cfg_model = w & 16'hfff1;      // bits 3:1 reserved
    endtask

    task automatic check_cfg();
        send_request(1'b0, 1'b1, ACC_2B, '0, '0);
        expect_fault(1'b0);
        wait_resp(REG_TIMEOUT);
        checks++;
        if (!seen) begin
            report_error($sformatf("no resp within %0d cycles to a register read", REG_TIMEOUT));
        end else if (got !== BUS_W'(cfg_model)) begin
            report_mismatch("rdata", got, BUS_W'(cfg_model));
        end
    endtask

    task automatic flash_read(logic [ACC_W-1:0] sz, logic [ADDR_W-1:0] a);
        logic [BUS_W-1:0] exp_v;
        logic [BUS_W-1:0] d;
        exp_v = expected_read(a, sz);
        d     = rand_bits(32);
        send_request(1'b0, 1'b0, sz, a, d);
        expect_fault(1'b0);
        wait_resp(RD_TIMEOUT);
        checks++;
        if (!seen) begin
            report_error($sformatf("no resp within %0d cycles to a flash read at 0x%04h",
                                   RD_TIMEOUT, a));
        end else if (got !== exp_v) begin
            report_mismatch("rdata", got, exp_v);
        end
    endtask

    task automatic run_reads(logic quad, int count);
        logic [7:0]        cmd;
        logic [3:0]        dummy;
        logic [2:0]        rsvd;
        logic [ACC_W-1:0]  sz;
        logic [ADDR_W-1:0] a;
        for (int i = 0; i < count; i++) begin
            cmd   = 8'(rand_bits(8));
            dummy = 4'(rand_bits(4));
            rsvd  = 3'(rand_bits(3));
            sz    = 2'(rand_bits(2));
            a     = 16'(rand_bits(16));
            if (i == 0) begin
                dummy = 4'd0;          // both ends of the dummy range
            end
            if (i == 1) begin
                dummy = 4'd15;
            end
            write_cfg({cmd, dummy, rsvd, quad});
            flash_read(sz, a);
        end
    endtask

    task automatic expect_faulted(string what);
        expect_fault(1'b1);
        wait_resp(NO_RESP_WAIT);
        checks++;
        if (seen) begin
            report_error($sformatf("resp arrived after a faulted %s", what));
        end
    endtask

    task automatic run_faults(int rounds);
        logic [ACC_W-1:0]  sz;
        logic [ADDR_W-1:0] a;
        logic              wr;
        logic [BUS_W-1:0]  d;
        for (int i = 0; i < rounds; i++) begin
            sz = 2'(rand_bits(2));
            a  = 16'(rand_bits(16));
            d  = rand_bits(32);
            send_request(1'b1, 1'b0, sz, a, d);
            expect_faulted("write to the flash window");
            wr = 1'(rand_bits(1));
            a  = 16'(rand_bits(16));
            d  = rand_bits(32);
            if (a[2:0] == 3'd0) begin
                a[0] = 1'b1;
            end
            send_request(wr, 1'b1, ACC_2B, a, d);
            expect_faulted("register access at a nonzero address");
            wr = 1'(rand_bits(1));
            sz = 2'(rand_bits(2));
            d  = rand_bits(32);
            if (sz == ACC_2B) begin
                sz = ACC_4B;
            end
            send_request(wr, 1'b1, sz, '0, d);
            expect_faulted("register access with a wrong size");
            check_cfg();               // faulted writes leave the word alone
        end
    endtask

    task automatic finish_test(string name);
        $display("%s: %0d checks, %0d errors", name, checks - chk_mark,
                 errors + flash_errors - err_mark);
        chk_mark = checks;
        err_mark = errors + flash_errors;
    endtask

    initial begin
        clk        = 1'b0;
        rstn       = 1'b0;
        req        = 1'b0;
        wr_b       = 1'b0;
        ctrl_sel   = 1'b0;
        acc        = '0;
        addr       = '0;
        wdata      = '0;
        lfsr       = 32'd95189;
        cfg_model  = 16'h0300;         // reset word holds command 0x03 in single mode
        errors     = 0;
        checks     = 0;
        csb_errors = 0;
        csb_checks = 0;
        err_mark   = 0;
        chk_mark   = 0;
        repeat (5) @(posedge clk);
        rstn <= 1'b1;

        @(negedge clk);
        checks++;
        if (qspi_csb !== 1'b1) begin
            report_mismatch("qspi_csb", 32'(qspi_csb), 32'h1);
        end
        checks++;
        if (qspi_sck !== 1'b0) begin
            report_mismatch("qspi_sck", 32'(qspi_sck), 32'h0);
        end
        check_cfg();
        finish_test("test 1 reset state");

        for (int i = 0; i < 16; i++) begin
            write_cfg(16'(rand_bits(16)));
            check_cfg();
        end
        finish_test("test 2 register write and read-back");

        run_reads(1'b0, 14);
        finish_test("test 3 single mode flash reads");

        run_reads(1'b1, 14);
        finish_test("test 4 quad mode flash reads");

        run_faults(4);
        finish_test("test 5 faulted requests");

        $display("test 6 csb idle between transactions: %0d checks, %0d errors",
                 csb_checks, csb_errors);

        $display("tests: 6, checks: %0d, errors: %0d", checks + csb_checks,
                 errors + csb_errors + flash_errors);
        if (errors + csb_errors + flash_errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
